//--- list.f
+incdir+source
source/axi_pkg.sv
source/fetch_pkg.sv
source/axi_read_if.sv
source/pc_stage.sv
source/icache.sv
source/predecode.sv
source/fetch_top.sv
bench/mem_model.sv
bench/fetch_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module fetch_tb \
  --Mdir obj_dir -o fetch_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/fetch_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
  echo "simulation reported failure, see sim.log"
  exit 1
fi

if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

exit 0

//--- bench/fetch_tb.sv
`timescale 1ns/1ps

`include "fetch_config.svh"

module fetch_tb import axi_pkg::*, fetch_pkg::*; ();

  localparam logic [31:0] no_redirect = 32'hffff_ffff;
  localparam int          max_wait    = 200;
  localparam axi_id_t     fetch_id    = '0; // one read id for every line refill

  typedef struct {
    string       name;
    logic [31:0] target;       // no_redirect keeps the stream going
    int          outputs;
    int          stall_cycles; // held after the first output
    logic [15:0] refills;      // running total at the last output
  } row_t;

  logic                     clock;
  logic                     reset;
  logic [`FETCH_ADDR_W-1:0] boot_pc;
  logic                     redirect;
  logic [`FETCH_ADDR_W-1:0] redirect_pc;
  logic                     stall;
  logic [`FETCH_ADDR_W-1:0] axi_araddr;
  axi_len_t                 axi_arlen;
  axi_size_t                axi_arsize;
  axi_burst_t               axi_arburst;
  axi_id_t                  axi_arid;
  logic                     axi_arvalid;
  logic                     axi_arready;
  logic [`FETCH_BUS_W-1:0]  axi_rdata;
  logic                     axi_rlast;
  logic                     axi_rvalid;
  logic                     axi_rready;
  logic                     out_valid;
  logic [`FETCH_ADDR_W-1:0] out_pc;
  logic [31:0]              out_word;
  inst_class_t              out_class;
  logic signed [31:0]       out_imm;
  logic [15:0]              refill_count;

  row_t        rows [9];
  logic [31:0] next_pc;

  fetch_top i_dut (
    .clock(clock), .reset(reset), .boot_pc(boot_pc), .redirect(redirect),
    .redirect_pc(redirect_pc), .stall(stall),
    .axi_araddr(axi_araddr), .axi_arlen(axi_arlen), .axi_arsize(axi_arsize),
    .axi_arburst(axi_arburst), .axi_arid(axi_arid), .axi_arvalid(axi_arvalid),
    .axi_arready(axi_arready), .axi_rdata(axi_rdata), .axi_rlast(axi_rlast),
    .axi_rvalid(axi_rvalid), .axi_rready(axi_rready),
    .out_valid(out_valid), .out_pc(out_pc), .out_word(out_word),
    .out_class(out_class), .out_imm(out_imm), .refill_count(refill_count)
  );

  mem_model i_mem (
    .clock(clock), .reset(reset), .araddr(axi_araddr), .arlen(axi_arlen),
    .arvalid(axi_arvalid), .arready(axi_arready), .rdata(axi_rdata),
    .rlast(axi_rlast), .rvalid(axi_rvalid), .rready(axi_rready)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_pc(input string test, input logic [`FETCH_ADDR_W-1:0] expected,
                          input logic [`FETCH_ADDR_W-1:0] actual);
    if (actual !== expected) begin
      $display("** Error %s: pc expected %h actual %h", test, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_word(input string test, input inst_word_u expected,
                            input inst_word_u actual);
    if (actual !== expected) begin
      $display("** Error %s: word expected %h actual %h", test, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_class(input string test, input inst_class_t expected,
                             input inst_class_t actual);
    if (actual !== expected) begin
      $display("** Error %s: class expected %s actual %s", test, expected.name(),
               actual.name());
      abort_run();
    end
  endtask

  task automatic check_imm(input string test, input logic signed [31:0] expected,
                           input logic signed [31:0] actual);
    if (actual !== expected) begin
      $display("** Error %s: imm expected %0d actual %0d", test, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_count(input string test, input logic [15:0] expected,
                             input logic [15:0] actual);
    if (actual !== expected) begin
      $display("** Error %s: refill count expected %0d actual %0d", test, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_len(input string test, input axi_len_t expected,
                           input axi_len_t actual);
    if (actual !== expected) begin
      $display("** Error %s: arlen expected %0d actual %0d", test, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_size(input string test, input axi_size_t expected,
                            input axi_size_t actual);
    if (actual !== expected) begin
      $display("** Error %s: arsize expected %0d actual %0d", test, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_burst(input string test, input axi_burst_t expected,
                             input axi_burst_t actual);
    if (actual !== expected) begin
      $display("** Error %s: arburst expected %s actual %s", test, expected.name(),
               actual.name());
      abort_run();
    end
  endtask

  task automatic check_id(input string test, input axi_id_t expected,
                          input axi_id_t actual);
    if (actual !== expected) begin
      $display("** Error %s: arid expected %0d actual %0d", test, expected, actual);
      abort_run();
    end
  endtask

  // a line refill is one wrap burst of two 8 byte beats
  task automatic check_request(input string test);
    check_len(test, axi_len_t'(1), axi_arlen);
    check_size(test, axi_size_t'(3), axi_arsize);
    check_burst(test, burst_wrap, axi_arburst);
    check_id(test, fetch_id, axi_arid);
  endtask

  // RV32 opcode and immediate layouts
  function automatic inst_class_t expected_class(input logic [31:0] w);
    case (w[6:0])
      7'b1100011:             return class_branch;
      7'b1101111, 7'b1100111: return class_jump;
      default:                return class_other;
    endcase
  endfunction

  function automatic logic signed [31:0] expected_imm(input logic [31:0] w);
    case (w[6:0])
      7'b1100011: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      7'b1101111: return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      7'b1100111: return {{20{w[31]}}, w[31:20]};
      default:    return '0;
    endcase
  endfunction

  task automatic wait_output(input string test);
    int waited;
    waited = 0;
    do begin
      @(negedge clock);
      waited++;
      if (axi_arvalid) begin
        check_request(test);
      end
    end while (!out_valid && waited < max_wait);
    if (!out_valid) begin
      $display("%s: no fetch output within %0d cycles", test, max_wait);
      abort_run();
    end
  endtask

  task automatic hold_stall(input string test, input int cycles);
    stall = 1'b1;
    repeat (cycles) begin
      @(negedge clock);
      if (out_valid) begin
        $display("%s: out_valid appeared while stall was high", test);
        abort_run();
      end
    end
    stall = 1'b0;
  endtask

  task automatic run_row(input row_t r);
    logic [31:0] word_exp;
    string       test;
    if (r.target != no_redirect) begin
      redirect    = 1'b1;
      redirect_pc = r.target;
      stall       = 1'b1; // no output from the old stream
      @(negedge clock);
      redirect    = 1'b0;
      stall       = 1'b0;
      next_pc     = r.target;
    end
    for (int n = 0; n < r.outputs; n++) begin
      wait_output(r.name);
      test     = $sformatf("%s pc %h", r.name, next_pc);
      word_exp = i_mem.words[next_pc[9:2]];
      check_pc(test, next_pc, out_pc);
      check_word(test, word_exp, out_word);
      check_class(test, expected_class(word_exp), out_class);
      check_imm(test, expected_imm(word_exp), out_imm);
      next_pc = next_pc + 32'd4;
      if (n == 0 && r.stall_cycles > 0) begin
        hold_stall(r.name, r.stall_cycles);
      end
    end
    check_count(r.name, r.refills, refill_count);
  endtask

  initial begin
    reset       = 1'b1;
    boot_pc     = '0;
    redirect    = 1'b0;
    redirect_pc = '0;
    stall       = 1'b0;
    rows[0] = '{"cold_miss", no_redirect, 1, 0, 16'd1};
    rows[1] = '{"sequential", no_redirect, 6, 0, 16'd2};   // crosses into line 0x10
    rows[2] = '{"rerun", 32'h0000_0000, 7, 0, 16'd2};
    rows[3] = '{"critical_word", 32'h0000_0028, 4, 0, 16'd4};
    rows[4] = '{"conflict_to_40", 32'h0000_0040, 2, 0, 16'd5};
    rows[5] = '{"conflict_to_00", 32'h0000_0000, 2, 0, 16'd6};
    rows[6] = '{"conflict_back_40", 32'h0000_0040, 2, 0, 16'd7};
    rows[7] = '{"predecode", 32'h0000_0080, 4, 0, 16'd8};
    rows[8] = '{"stall", no_redirect, 6, 5, 16'd10};       // 0x90 then 0xa0 lines
    repeat (3) @(negedge clock);
    reset   = 1'b0;
    next_pc = boot_pc;
    foreach (rows[i]) begin
      run_row(rows[i]);
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- bench/mem_model.sv
`timescale 1ns/1ps

`include "fetch_config.svh"

module mem_model import axi_pkg::*; (
  input  logic                     clock,
  input  logic                     reset,
  input  logic [`FETCH_ADDR_W-1:0] araddr,
  input  axi_len_t                 arlen,
  input  logic                     arvalid,
  output logic                     arready,
  output logic [`FETCH_BUS_W-1:0]  rdata,
  output logic                     rlast,
  output logic                     rvalid,
  input  logic                     rready
);

  logic [31:0] words [256]; // 1 KB image repeating above
  logic [31:0] rand_state;
  logic [31:0] start_addr;
  logic        busy;
  logic        rready_held;
  int          beats;
  int          beat;
  int          wait_cycles;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  task automatic draw_delay();
    rand_state  = xorshift(rand_state);
    wait_cycles = int'(rand_state[1:0]); // 0 to 3 cycles
  endtask

  // wrap burst stays inside one aligned block of beats
  function automatic logic [`FETCH_BUS_W-1:0] beat_data(input int k);
    logic [31:0] span;
    logic [31:0] low;
    logic [31:0] addr;
    span = 32'(beats) * 32'd8;
    low  = start_addr % span;
    addr = start_addr - low + (low + 32'(k) * 32'd8) % span;
    return {words[8'((addr >> 2) + 32'd1)], words[8'(addr >> 2)]};
  endfunction

  initial begin
    for (int i = 0; i < 256; i++) begin
      words[i] = {8'hc0 ^ 8'(i), 8'(i), ~8'(i), 8'h13}; // addi filler
    end
    words[32]   = 32'hfe208ce3; // 0x80 beq x1, x2, -8
    words[33]   = 32'hff9ff0ef; // jal ra, backwards
    words[34]   = 32'hffc08067; // jalr x0, -4(x1)
    words[35]   = 32'h002081b3; // add x3, x1, x2
    arready     = 1'b0;
    rvalid      = 1'b0;
    rlast       = 1'b0;
    rdata       = '0;
    busy        = 1'b0;
    rready_held = 1'b0;
    start_addr  = '0;
    beats       = 1;
    beat        = 0;
    rand_state  = 32'd17;
    draw_delay();
    forever begin
      @(negedge clock);
      if (reset) begin
        arready = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        busy    = 1'b0;
      end else begin
        if (arready) begin
          // arvalid was held, so the address went at the last edge
          arready = 1'b0;
          busy    = 1'b1;
          beat    = 0;
          draw_delay();
        end else if (!busy && arvalid) begin
          if (wait_cycles == 0) begin
            arready    = 1'b1;
            start_addr = araddr;
            beats      = int'(arlen) + 1;
          end else begin
            wait_cycles--;
          end
        end
        if (rvalid && rready_held) begin
          rvalid = 1'b0;
          rlast  = 1'b0;
          beat++;
          busy   = (beat < beats);
          draw_delay();
        end
        if (busy && !rvalid) begin
          if (wait_cycles == 0) begin
            rvalid = 1'b1;
            rdata  = beat_data(beat);
            rlast  = (beat == beats - 1);
          end else begin
            wait_cycles--;
          end
        end
        rready_held = rready; // level seen by the coming edge
      end
    end
  end

endmodule

//--- source/fetch_top.sv
`timescale 1ns/1ps

`include "fetch_config.svh"

module fetch_top import axi_pkg::*, fetch_pkg::*; (
  input  logic                     clock,
  input  logic                     reset,
  input  logic [`FETCH_ADDR_W-1:0] boot_pc,
  input  logic                     redirect,
  input  logic [`FETCH_ADDR_W-1:0] redirect_pc,
  input  logic                     stall,

  output logic [`FETCH_ADDR_W-1:0] axi_araddr,
  output axi_len_t                 axi_arlen,
  output axi_size_t                axi_arsize,
  output axi_burst_t               axi_arburst,
  output axi_id_t                  axi_arid,
  output logic                     axi_arvalid,
  input  logic                     axi_arready,
  input  logic [`FETCH_BUS_W-1:0]  axi_rdata,
  input  logic                     axi_rlast,
  input  logic                     axi_rvalid,
  output logic                     axi_rready,

  output logic                     out_valid,
  output logic [`FETCH_ADDR_W-1:0] out_pc,
  output logic [31:0]              out_word,
  output inst_class_t              out_class,
  output logic signed [31:0]       out_imm,
  output logic [15:0]              refill_count
);

  logic [`FETCH_ADDR_W-1:0] fetch_pc;
  logic                     hit;
  inst_word_u               word;
  fetch_out_t               fetched;

  axi_read_if i_axi ();

  pc_stage i_pc_stage (
    .clock       (clock),
    .reset       (reset),
    .boot_pc     (boot_pc),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .stall       (stall),
    .hit         (hit),
    .fetch_pc    (fetch_pc)
  );

  icache i_icache (
    .clock        (clock),
    .reset        (reset),
    .fetch_pc     (fetch_pc),
    .hit          (hit),
    .word         (word),
    .refill_count (refill_count),
    .mem          (i_axi.master)
  );

  predecode i_predecode (
    .clock     (clock),
    .reset     (reset),
    .fetch_pc  (fetch_pc),
    .hit       (hit),
    .stall     (stall),
    .word      (word),
    .out_valid (out_valid),
    .out       (fetched)
  );

  // bundle to flat AXI pins
  assign axi_araddr    = i_axi.araddr;
  assign axi_arlen     = i_axi.arlen;
  assign axi_arsize    = i_axi.arsize;
  assign axi_arburst   = i_axi.arburst;
  assign axi_arid      = i_axi.arid;
  assign axi_arvalid   = i_axi.arvalid;
  assign axi_rready    = i_axi.rready;
  assign i_axi.arready = axi_arready;
  assign i_axi.rdata   = axi_rdata;
  assign i_axi.rlast   = axi_rlast;
  assign i_axi.rvalid  = axi_rvalid;

  assign out_pc    = fetched.pc;
  assign out_word  = fetched.word;
  assign out_class = fetched.iclass;
  assign out_imm   = fetched.imm;

endmodule

//--- source/predecode.sv
`timescale 1ns/1ps

`include "fetch_config.svh"

module predecode import fetch_pkg::*; (
  input  logic                     clock,
  input  logic                     reset,
  input  logic [`FETCH_ADDR_W-1:0] fetch_pc,
  input  logic                     hit,
  input  logic                     stall,
  input  inst_word_u               word,
  output logic                     out_valid,
  output fetch_out_t               out
);

  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;

  logic               accept;
  inst_class_t        next_class;
  logic signed [31:0] next_imm;

  assign accept = hit && !stall;

  always_comb begin
    next_class = class_other;
    next_imm   = '0;
    case (word.rtype.opcode)
      op_branch: begin
        next_class = class_branch;
        next_imm   = {{19{word.btype.imm12}}, word.btype.imm12, word.btype.imm11,
                      word.btype.imm10_5, word.btype.imm4_1, 1'b0};
      end
      op_jal: begin
        // J format scattered over the rtype fields
        next_class = class_jump;
        next_imm   = {{11{word.rtype.funct7[6]}}, word.rtype.funct7[6],
                      word.rtype.rs1, word.rtype.funct3, word.rtype.rs2[0],
                      word.rtype.funct7[5:0], word.rtype.rs2[4:1], 1'b0};
      end
      op_jalr: begin
        next_class = class_jump;
        next_imm   = {{20{word.rtype.funct7[6]}}, word.rtype.funct7, word.rtype.rs2}; // I format
      end
      default: ;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= accept; // one pulse per accepted fetch
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      out.pc     <= fetch_pc;
      out.word   <= word;
      out.iclass <= next_class;
      out.imm    <= next_imm;
    end
  end

endmodule

//--- source/icache.sv
`timescale 1ns/1ps

`include "fetch_config.svh"

module icache import axi_pkg::*, fetch_pkg::*; (
  input  logic                     clock,
  input  logic                     reset,
  input  logic [`FETCH_ADDR_W-1:0] fetch_pc,
  output logic                     hit,
  output inst_word_u               word,
  output logic [15:0]              refill_count,
  axi_read_if.master               mem
);

  localparam int TAG_W          = `FETCH_ADDR_W - `FETCH_OFFSET_W - `FETCH_INDEX_W;
  localparam int SETS           = 1 << `FETCH_INDEX_W;
  localparam int WORD_OFF_W     = `FETCH_OFFSET_W - 2;
  localparam int WORDS          = 1 << WORD_OFF_W;
  localparam int BUS_BYTES_W    = $clog2(`FETCH_BUS_W / 8);
  localparam int BEAT_W         = `FETCH_OFFSET_W - BUS_BYTES_W;
  localparam int WORDS_PER_BEAT = `FETCH_BUS_W / 32;

  typedef enum logic [2:0] {
    s_idle     = 3'b001,
    s_request  = 3'b010,
    s_response = 3'b100
  } state_t;

  state_t state, state_next;

  logic [SETS-1:0]  line_valid;
  logic [TAG_W-1:0] line_tag  [SETS];
  logic [31:0]      line_data [SETS][WORDS];

  logic [TAG_W-1:0]          fetch_tag;
  logic [`FETCH_INDEX_W-1:0] fetch_index;
  logic [WORD_OFF_W-1:0]     fetch_word;
  logic                      lookup_match;

  // line under refill stays put across a redirect
  logic [TAG_W-1:0]          miss_tag;
  logic [`FETCH_INDEX_W-1:0] miss_index;
  logic [BEAT_W-1:0]         beat;

  logic start_refill;
  logic addr_fire;
  logic beat_fire;

  assign fetch_tag   = fetch_pc[`FETCH_ADDR_W-1 -: TAG_W];
  assign fetch_index = fetch_pc[`FETCH_OFFSET_W +: `FETCH_INDEX_W];
  assign fetch_word  = fetch_pc[2 +: WORD_OFF_W];

  assign lookup_match = line_valid[fetch_index] && (line_tag[fetch_index] == fetch_tag);
  assign hit  = (state == s_idle) && lookup_match; // no hits while a line is being filled
  assign word = line_data[fetch_index][fetch_word];

  assign start_refill = (state == s_idle) && !lookup_match;
  assign addr_fire    = mem.arvalid && mem.arready;
  assign beat_fire    = mem.rvalid && mem.rready;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= s_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    unique case (state)
      s_idle:     if (start_refill) state_next = s_request;
      s_request:  if (mem.arready) state_next = s_response;
      s_response: if (beat_fire && mem.rlast) state_next = s_idle;
      default:    state_next = s_idle;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      beat <= '0;
    end else if (start_refill) begin
      beat <= fetch_pc[BUS_BYTES_W +: BEAT_W]; // critical beat goes first
    end else if (beat_fire) begin
      beat <= beat + 1'b1; // wraps with the burst
    end
  end

  always_ff @(posedge clock) begin
    if (start_refill) begin
      miss_tag   <= fetch_tag;
      miss_index <= fetch_index;
    end
  end

  assign mem.arvalid = (state == s_request);
  assign mem.araddr  = {miss_tag, miss_index, beat, {BUS_BYTES_W{1'b0}}};
  assign mem.arlen   = axi_len_t'((1 << BEAT_W) - 1);
  assign mem.arsize  = axi_size_t'(BUS_BYTES_W);
  assign mem.arburst = burst_wrap;
  assign mem.arid    = '0;
  assign mem.rready  = (state == s_response);

  // each beat fills two adjacent words
  always_ff @(posedge clock) begin
    if (beat_fire) begin
      for (int h = 0; h < WORDS_PER_BEAT; h++) begin
        line_data[miss_index][WORD_OFF_W'(beat * WORDS_PER_BEAT + h)] <= mem.rdata[h*32 +: 32];
      end
      if (mem.rlast) begin
        line_tag[miss_index] <= miss_tag;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      line_valid <= '0;
    end else if (beat_fire && mem.rlast) begin
      line_valid[miss_index] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      refill_count <= '0;
    end else if (addr_fire) begin
      refill_count <= refill_count + 16'd1;
    end
  end

  // memory side must not push data the cache never asked for
  a_beat_in_response: assert property (
    @(posedge clock) disable iff (reset)
    mem.rvalid |-> state == s_response
  );

endmodule

//--- source/pc_stage.sv
`timescale 1ns/1ps

`include "fetch_config.svh"

module pc_stage (
  input  logic                     clock,
  input  logic                     reset,
  input  logic [`FETCH_ADDR_W-1:0] boot_pc,
  input  logic                     redirect,
  input  logic [`FETCH_ADDR_W-1:0] redirect_pc,
  input  logic                     stall,
  input  logic                     hit,
  output logic [`FETCH_ADDR_W-1:0] fetch_pc
);

  logic [`FETCH_ADDR_W-1:0] pc;
  logic                     advance;

  assign advance = hit && !stall; // word accepted by predecode this edge

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= boot_pc;
    end else if (redirect) begin
      pc <= redirect_pc; // external target beats sequential step
    end else if (advance) begin
      pc <= pc + `FETCH_ADDR_W'(4);
    end
  end

  assign fetch_pc = pc;

  // a misaligned boot or redirect target would fetch the wrong word of a line
  a_pc_aligned: assert property (
    @(posedge clock) disable iff (reset)
    fetch_pc[1:0] == 2'b00
  );

endmodule

//--- source/axi_read_if.sv
`timescale 1ns/1ps

`include "fetch_config.svh"

interface axi_read_if import axi_pkg::*; ();

  // read address channel
  logic [`FETCH_ADDR_W-1:0] araddr;
  axi_len_t                 arlen;
  axi_size_t                arsize;
  axi_burst_t               arburst;
  axi_id_t                  arid;
  logic                     arvalid;
  logic                     arready;

  // read data channel
  logic [`FETCH_BUS_W-1:0]  rdata;
  logic                     rlast;
  logic                     rvalid;
  logic                     rready;

  modport master (
    output araddr, arlen, arsize, arburst, arid, arvalid, rready,
    input  arready, rdata, rlast, rvalid
  );

  modport slave (
    input  araddr, arlen, arsize, arburst, arid, arvalid, rready,
    output arready, rdata, rlast, rvalid
  );

endinterface

//--- source/fetch_pkg.sv
package fetch_pkg;

  `include "fetch_config.svh"

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rtype_t;

  // conditional branch layout with the immediate split around the registers
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } btype_t;

  typedef union packed {
    rtype_t rtype;
    btype_t btype;
  } inst_word_u;

  typedef enum logic [1:0] {
    class_other,
    class_branch,
    class_jump
  } inst_class_t;

  typedef struct packed {
    logic [`FETCH_ADDR_W-1:0] pc;
    inst_word_u               word;
    inst_class_t              iclass;
    logic signed [31:0]       imm;
  } fetch_out_t;

endpackage

//--- source/axi_pkg.sv
package axi_pkg;

  // burst length, beats minus one
  typedef logic [7:0] axi_len_t;

  // log2 of bytes per beat
  typedef logic [2:0] axi_size_t;

  typedef enum logic [1:0] {
    burst_fixed = 2'b00,
    burst_incr  = 2'b01,
    burst_wrap  = 2'b10
  } axi_burst_t;

  // icache issues a single transaction id
  typedef logic [3:0] axi_id_t;

endpackage

//--- source/fetch_config.svh
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// fetch address width
`define FETCH_ADDR_W 32

// byte offset within a 16 byte line
`define FETCH_OFFSET_W 4

// set index for four sets
`define FETCH_INDEX_W 2

// AXI read data width
`define FETCH_BUS_W 64

`endif
